// ==== build.f ====
+incdir+src
src/usb_ctrl_pkg.sv
src/setup_decoder.sv
src/ctrl_transfer_fsm.sv
src/in_stage_source.sv
src/usb_ctrl_endp.sv
testbench/usb_ctrl_endp_sva.sv
testbench/tb_usb_ctrl_endp.sv

// ==== src/ctrl_transfer_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module ctrl_transfer_fsm (
   input  wire logic                     clk_i,
   input  wire logic                     rstn,
   input  wire logic                     usb_reset_i,
   input  wire usb_ctrl_pkg::sie_rx_t    sie_i,
   input  wire usb_ctrl_pkg::setup_req_t req_i,
   input  wire logic                     req_done_i,
   input  wire logic                     data_exhausted_i,
   output usb_ctrl_pkg::req_kind_e       stage_src_o,
   output logic [`USB_LEN_W-1:0]         length_o,
   output logic                          status_zlp_o,
   output usb_ctrl_pkg::dev_state_e      dev_state_o,
   output logic [`USB_ADDR_W-1:0]        addr_o,
   output logic                          stall_o,
   output logic                          configured_o,
   output logic                          usb_en_o
);

   typedef enum logic [2:0] {
      st_idle   = 3'd0,
      st_setup  = 3'd1,
      st_data   = 3'd2,
      st_status = 3'd3,
      st_stall  = 3'd4
   } stage_e;

   stage_e                    state_q, state_d;
   usb_ctrl_pkg::req_kind_e   kind_q;
   logic [`USB_LEN_W-1:0]     length_q;
   usb_ctrl_pkg::dev_state_e  dev_state_q, dev_state_d;
   logic [`USB_ADDR_W-1:0]    addr_q, addr_d;
   logic [`USB_ADDR_W-1:0]    addr_pend_q;
   logic                      cfg_pend_q;
   logic                      usb_en_q;
   logic                      step;     // clock enable
   logic                      end_stb;

   // in_req only matters once the data runs out
   assign step    = sie_i.out_ready | sie_i.in_ready | req_done_i | sie_i.in_req;
   assign end_stb = sie_i.out_ready & ~(sie_i.out_valid | sie_i.out_err |
                                        sie_i.setup | sie_i.in_data_ack);

   always_comb begin
      state_d     = state_q;
      dev_state_d = dev_state_q;
      addr_d      = addr_q;
      if (sie_i.out_ready && sie_i.out_err) begin
         if (state_q != st_stall)
            state_d = st_idle;
      end else if (sie_i.out_ready && sie_i.setup) begin
         state_d = st_setup;
      end else begin
         case (state_q)
            st_setup: begin
               if (req_done_i) begin
                  if (req_i.kind == usb_ctrl_pkg::req_unsupported)
                     state_d = st_stall;
                  else if (req_i.in_dir)
                     state_d = st_data;
                  else
                     state_d = st_status;  // OUT requests carry no data
               end
            end
            st_data: begin
               if (sie_i.out_ready && sie_i.out_valid)
                  state_d = st_stall;
               else if (end_stb)
                  state_d = st_idle;      // host status ZLP
               else if (sie_i.in_req && data_exhausted_i)
                  state_d = st_stall;
            end
            st_status: begin
               if (sie_i.out_ready && sie_i.in_data_ack) begin
                  state_d = st_idle;
                  if (kind_q == usb_ctrl_pkg::req_set_address) begin
                     addr_d      = addr_pend_q;
                     dev_state_d = (addr_pend_q == '0) ? usb_ctrl_pkg::dev_default :
                                                         usb_ctrl_pkg::dev_address;
                  end else if (kind_q == usb_ctrl_pkg::req_set_config) begin
                     dev_state_d = cfg_pend_q ? usb_ctrl_pkg::dev_configured :
                                                usb_ctrl_pkg::dev_address;
                  end
               end else if (sie_i.out_ready && sie_i.out_valid) begin
                  state_d = st_stall;
               end
            end
            default: ;  // idle and stall wait for a SETUP
         endcase
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         state_q     <= st_idle;
         kind_q      <= usb_ctrl_pkg::req_none;
         length_q    <= '0;
         dev_state_q <= usb_ctrl_pkg::dev_powered;
         addr_q      <= '0;
         usb_en_q    <= 1'b0;
      end else if (usb_reset_i) begin
         state_q     <= st_idle;
         kind_q      <= usb_ctrl_pkg::req_none;
         dev_state_q <= usb_ctrl_pkg::dev_default;
         addr_q      <= '0;
         usb_en_q    <= 1'b1;   // stays up from the first bus reset
      end else if (step) begin
         state_q     <= state_d;
         dev_state_q <= dev_state_d;
         addr_q      <= addr_d;
         if (req_done_i) begin
            kind_q   <= req_i.kind;
            length_q <= req_i.length;
         end
      end
   end

   // values wait here until the status stage is ACKed
   always_ff @(posedge clk_i) begin
      if (req_done_i) begin
         addr_pend_q <= req_i.value[`USB_ADDR_W-1:0];
         cfg_pend_q  <= req_i.value[0];
      end
   end

   assign stage_src_o  = (state_q == st_data) ? kind_q : usb_ctrl_pkg::req_none;
   assign length_o     = length_q;
   assign status_zlp_o = (state_q == st_status);
   assign dev_state_o  = dev_state_q;
   assign addr_o       = addr_q;
   assign stall_o      = (state_q == st_stall);
   assign configured_o = (dev_state_q == usb_ctrl_pkg::dev_configured);
   assign usb_en_o     = usb_en_q;

endmodule

`default_nettype wire

// ==== src/in_stage_source.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module in_stage_source (
   input  wire logic                     clk_i,
   input  wire logic                     rstn,
   input  wire usb_ctrl_pkg::sie_rx_t    sie_i,
   input  wire usb_ctrl_pkg::req_kind_e  stage_src_i,
   input  wire logic [`USB_LEN_W-1:0]    length_i,
   input  wire logic                     status_zlp_i,
   input  wire usb_ctrl_pkg::dev_state_e dev_state_i,
   output usb_ctrl_pkg::in_pkt_t         in_pkt_o,
   output logic                          data_exhausted_o
);

   localparam logic [15:0] bcd_usb = `USB_BCD_USB;
   localparam logic [15:0] vid     = `USB_VENDOR_ID;
   localparam logic [15:0] pid     = `USB_PRODUCT_ID;
   localparam logic [15:0] bcd_dev = `USB_BCD_DEVICE;
   localparam logic [`USB_LEN_W-1:0] descr_len = `USB_DEV_DESCR_LEN;

   // device descriptor, index 0 goes out first
   localparam logic [0:`USB_DEV_DESCR_LEN-1][7:0] dev_descr = {
      8'(`USB_DEV_DESCR_LEN), `USB_DESCR_DEVICE,
      bcd_usb[7:0], bcd_usb[15:8],
      `USB_DEV_CLASS, 8'h00, 8'h00,       // class, subclass, protocol
      8'(`USB_EP0_MAXPKT),
      vid[7:0], vid[15:8],
      pid[7:0], pid[15:8],
      bcd_dev[7:0], bcd_dev[15:8],
      8'h00, 8'h00, 8'h00,                // no strings
      8'h01                               // one configuration
   };

   logic                  in_req_q;
   logic [`USB_LEN_W-1:0] cnt_q;
   logic [`USB_LEN_W-1:0] limit;
   logic                  data_stage;
   logic                  exhausted;
   logic [7:0]            data;

   assign data_stage = (stage_src_i != usb_ctrl_pkg::req_none);

   // descriptor sends min(wLength, 18), GET_CONFIGURATION one byte
   assign limit = (stage_src_i == usb_ctrl_pkg::req_get_dev_descr) ?
                  ((length_i < descr_len) ? length_i : descr_len) : `USB_LEN_W'(1);
   assign exhausted = data_stage & (cnt_q >= limit);

   always_comb begin
      data = 8'h00;
      if (stage_src_i == usb_ctrl_pkg::req_get_dev_descr) begin
         if (cnt_q < descr_len)
            data = dev_descr[cnt_q];
      end else if (dev_state_i == usb_ctrl_pkg::dev_configured) begin
         data = 8'h01;  // bConfigurationValue
      end
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         in_req_q <= 1'b0;
         cnt_q    <= '0;
      end else begin
         in_req_q <= sie_i.in_req;
         if (!data_stage)
            cnt_q <= '0;
         else if (sie_i.in_ready && in_pkt_o.valid && !in_pkt_o.zlp)
            cnt_q <= cnt_q + 1'b1;  // byte taken by SIE
      end
   end

   assign in_pkt_o.data  = data;
   assign in_pkt_o.zlp   = in_req_q & status_zlp_i;
   assign in_pkt_o.valid = in_req_q & ((data_stage & ~exhausted) | status_zlp_i);
   assign data_exhausted_o = exhausted;

endmodule

`default_nettype wire

// ==== src/setup_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module setup_decoder (
   input  wire logic                     clk_i,
   input  wire logic                     rstn,
   input  wire logic                     usb_reset_i,
   input  wire usb_ctrl_pkg::sie_rx_t    sie_i,
   input  wire usb_ctrl_pkg::dev_state_e dev_state_i,
   output usb_ctrl_pkg::setup_req_t      req_o,
   output logic                          req_done_o
);

   logic [3:0]                byte_cnt_q;
   logic                      active_q;    // inside a SETUP packet
   usb_ctrl_pkg::req_kind_e   kind_q, kind_d;
   logic                      in_dir_q;
   logic [7:0]                value_q;
   logic [`USB_LEN_W-1:0]     len_q;
   logic                      req_done_q;
   logic                      byte_ok;
   logic                      state_ok;
   logic                      abort_stb, setup_stb, byte_stb, end_stb;

   assign abort_stb = sie_i.out_ready & sie_i.out_err;
   assign setup_stb = sie_i.out_ready & sie_i.setup & ~sie_i.out_err;
   assign byte_stb  = sie_i.out_ready & sie_i.out_valid & ~sie_i.out_err & ~sie_i.setup;
   assign end_stb   = sie_i.out_ready & ~(sie_i.out_valid | sie_i.out_err |
                                          sie_i.setup | sie_i.in_data_ack);

   // configuration requests need an assigned address
   assign state_ok = (dev_state_i == usb_ctrl_pkg::dev_address) ||
                     (dev_state_i == usb_ctrl_pkg::dev_configured);

   // per-byte field checks, bRequest picks the kind
   always_comb begin
      kind_d  = kind_q;
      byte_ok = 1'b1;
      case (byte_cnt_q)
         4'd0: byte_ok = (sie_i.out_data[6:0] == 7'd0); // standard, device recipient
         4'd1: begin
            if (kind_q == usb_ctrl_pkg::req_none) begin
               case (sie_i.out_data)
                  `USB_REQ_GET_DESCRIPTOR:
                     byte_ok = in_dir_q;
                  `USB_REQ_GET_CONFIGURATION:
                     byte_ok = in_dir_q & state_ok;
                  `USB_REQ_SET_ADDRESS:
                     byte_ok = ~in_dir_q;
                  `USB_REQ_SET_CONFIGURATION:
                     byte_ok = ~in_dir_q & state_ok;
                  default:
                     byte_ok = 1'b0;
               endcase
               case (sie_i.out_data)
                  `USB_REQ_GET_DESCRIPTOR:    kind_d = usb_ctrl_pkg::req_get_dev_descr;
                  `USB_REQ_GET_CONFIGURATION: kind_d = usb_ctrl_pkg::req_get_config;
                  `USB_REQ_SET_ADDRESS:       kind_d = usb_ctrl_pkg::req_set_address;
                  default:                    kind_d = usb_ctrl_pkg::req_set_config;
               endcase
            end
         end
         4'd2: begin // wValue low
            case (kind_q)
               usb_ctrl_pkg::req_set_address: byte_ok = ~sie_i.out_data[7];
               usb_ctrl_pkg::req_set_config:  byte_ok = (sie_i.out_data <= 8'd1);
               default:                       byte_ok = (sie_i.out_data == 8'd0);
            endcase
         end
         4'd3: begin // wValue high
            if (kind_q == usb_ctrl_pkg::req_get_dev_descr)
               byte_ok = (sie_i.out_data == `USB_DESCR_DEVICE);
            else
               byte_ok = (sie_i.out_data == 8'd0);
         end
         4'd4, 4'd5: byte_ok = (sie_i.out_data == 8'd0); // wIndex
         4'd6: begin // wLength low
            case (kind_q)
               usb_ctrl_pkg::req_get_config:    byte_ok = (sie_i.out_data == 8'd1);
               usb_ctrl_pkg::req_get_dev_descr: byte_ok = 1'b1;
               default:                         byte_ok = (sie_i.out_data == 8'd0);
            endcase
         end
         4'd7: begin // wLength high, descriptor length is clipped instead
            if (kind_q != usb_ctrl_pkg::req_get_dev_descr)
               byte_ok = (sie_i.out_data == 8'd0);
         end
         default: byte_ok = 1'b0; // more than 8 bytes
      endcase
      if (!byte_ok)
         kind_d = usb_ctrl_pkg::req_unsupported;
   end

   always_ff @(posedge clk_i or negedge rstn) begin
      if (!rstn) begin
         active_q   <= 1'b0;
         byte_cnt_q <= '0;
         kind_q     <= usb_ctrl_pkg::req_none;
         req_done_q <= 1'b0;
      end else if (usb_reset_i) begin
         active_q   <= 1'b0;
         byte_cnt_q <= '0;
         kind_q     <= usb_ctrl_pkg::req_none;
         req_done_q <= 1'b0;
      end else begin
         req_done_q <= end_stb & active_q;
         if (abort_stb) begin
            active_q <= 1'b0;   // drop the packet quietly
         end else if (setup_stb) begin
            active_q   <= 1'b1;
            byte_cnt_q <= '0;
            kind_q     <= usb_ctrl_pkg::req_none;
         end else if (byte_stb && active_q) begin
            kind_q <= kind_d;
            if (byte_cnt_q != 4'hf)
               byte_cnt_q <= byte_cnt_q + 4'd1;
         end else if (end_stb && active_q) begin
            active_q <= 1'b0;
            if (byte_cnt_q != 4'(`USB_SETUP_LEN))
               kind_q <= usb_ctrl_pkg::req_unsupported;
         end
      end
   end

   // request payload fields
   always_ff @(posedge clk_i) begin
      if (byte_stb && active_q) begin
         case (byte_cnt_q)
            4'd0: in_dir_q <= sie_i.out_data[7];
            4'd2: value_q  <= sie_i.out_data;
            4'd6: len_q    <= (|sie_i.out_data[7:`USB_LEN_W]) ? '1 :
                              sie_i.out_data[`USB_LEN_W-1:0];
            4'd7: if (sie_i.out_data != 8'd0) len_q <= '1;
            default: ;
         endcase
      end
   end

   assign req_o      = '{kind: kind_q, in_dir: in_dir_q, value: value_q, length: len_q};
   assign req_done_o = req_done_q;

endmodule

`default_nettype wire

// ==== src/usb_ctrl_consts.svh ====
`ifndef USB_CTRL_CONSTS_SVH
`define USB_CTRL_CONSTS_SVH

// packet and field sizes
`define USB_SETUP_LEN       8
`define USB_DEV_DESCR_LEN   18
`define USB_LEN_W           5    // wLength after clipping, max 31
`define USB_ADDR_W          7
`define USB_EP0_MAXPKT      8

// device descriptor field values
`define USB_VENDOR_ID       16'h1D50
`define USB_PRODUCT_ID      16'h6130
`define USB_BCD_USB         16'h0200
`define USB_BCD_DEVICE      16'h0100
`define USB_DEV_CLASS       8'h02

// standard request codes (bRequest)
`define USB_REQ_SET_ADDRESS         8'd5
`define USB_REQ_GET_DESCRIPTOR      8'd6
`define USB_REQ_GET_CONFIGURATION   8'd8
`define USB_REQ_SET_CONFIGURATION   8'd9

// descriptor type in wValue high byte
`define USB_DESCR_DEVICE    8'd1

`endif

// ==== src/usb_ctrl_endp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module usb_ctrl_endp (
   input  wire logic                  clk_i,
   input  wire logic                  rstn,
   input  wire logic                  usb_reset_i,
   input  wire usb_ctrl_pkg::sie_rx_t sie_i,
   output usb_ctrl_pkg::in_pkt_t      in_pkt_o,
   output logic [`USB_ADDR_W-1:0]     addr_o,
   output logic                       stall_o,
   output logic                       configured_o,
   output logic                       usb_en_o
);

   usb_ctrl_pkg::setup_req_t  req;
   logic                      req_done;
   usb_ctrl_pkg::req_kind_e   stage_src;
   logic [`USB_LEN_W-1:0]     length;
   logic                      status_zlp;
   usb_ctrl_pkg::dev_state_e  dev_state;
   logic                      data_exhausted;

   // SETUP bytes in, decoded request out
   setup_decoder u_setup_decoder (
      .clk_i       (clk_i),
      .rstn        (rstn),
      .usb_reset_i (usb_reset_i),
      .sie_i       (sie_i),
      .dev_state_i (dev_state),
      .req_o       (req),
      .req_done_o  (req_done)
   );

   ctrl_transfer_fsm u_ctrl_transfer_fsm (
      .clk_i            (clk_i),
      .rstn             (rstn),
      .usb_reset_i      (usb_reset_i),
      .sie_i            (sie_i),
      .req_i            (req),
      .req_done_i       (req_done),
      .data_exhausted_i (data_exhausted),
      .stage_src_o      (stage_src),
      .length_o         (length),
      .status_zlp_o     (status_zlp),
      .dev_state_o      (dev_state),
      .addr_o           (addr_o),
      .stall_o          (stall_o),
      .configured_o     (configured_o),
      .usb_en_o         (usb_en_o)
   );

   // IN data and status ZLP back to the SIE
   in_stage_source u_in_stage_source (
      .clk_i            (clk_i),
      .rstn             (rstn),
      .sie_i            (sie_i),
      .stage_src_i      (stage_src),
      .length_i         (length),
      .status_zlp_i     (status_zlp),
      .dev_state_i      (dev_state),
      .in_pkt_o         (in_pkt_o),
      .data_exhausted_o (data_exhausted)
   );

endmodule

`default_nettype wire

// ==== src/usb_ctrl_pkg.sv ====
`default_nettype none
`include "usb_ctrl_consts.svh"

package usb_ctrl_pkg;

   // USB 2.0 chapter 9 device states
   typedef enum logic [1:0] {
      dev_powered    = 2'd0,
      dev_default    = 2'd1,
      dev_address    = 2'd2,
      dev_configured = 2'd3
   } dev_state_e;

   typedef enum logic [2:0] {
      req_none          = 3'd0,
      req_get_dev_descr = 3'd1,
      req_get_config    = 3'd2,
      req_set_address   = 3'd3,
      req_set_config    = 3'd4,
      req_unsupported   = 3'd5
   } req_kind_e;

   // decoded SETUP packet
   typedef struct packed {
      req_kind_e              kind;
      logic                   in_dir;   // bmRequestType[7]
      logic [7:0]             value;    // wValue low byte
      logic [`USB_LEN_W-1:0]  length;   // clipped wLength
   } setup_req_t;

   // SIE to endpoint
   typedef struct packed {
      logic [7:0] out_data;
      logic       out_valid;
      logic       out_err;
      logic       setup;
      logic       out_ready;   // one-cycle strobe
      logic       in_data_ack;
      logic       in_req;
      logic       in_ready;    // one-cycle strobe
   } sie_rx_t;

   // endpoint to SIE
   typedef struct packed {
      logic [7:0] data;
      logic       zlp;
      logic       valid;
   } in_pkt_t;

endpackage

`default_nettype wire

// ==== testbench/tb_usb_ctrl_endp.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "usb_ctrl_consts.svh"

module tb_usb_ctrl_endp;

   // about 20 control transfers of up to 60 cycles each, plus reset
   localparam int num_transfers  = 20;
   localparam int timeout_cycles = (num_transfers * 60 + 16) * 2;

   logic                   clk_i;
   logic                   rstn;
   logic                   usb_reset;
   usb_ctrl_pkg::sie_rx_t  sie;
   usb_ctrl_pkg::in_pkt_t  in_pkt;
   logic [`USB_ADDR_W-1:0] addr;
   logic                   stall;
   logic                   configured;
   logic                   usb_en;
   logic [7:0]             rx_buf [0:31];   // bytes collected by read_in
   logic [31:0]            rng;
   int                     errors;
   int                     checks;
   int                     tests_failed;
   int                     cycle_cnt;

   usb_ctrl_endp uut (
      .clk_i        (clk_i),
      .rstn         (rstn),
      .usb_reset_i  (usb_reset),
      .sie_i        (sie),
      .in_pkt_o     (in_pkt),
      .addr_o       (addr),
      .stall_o      (stall),
      .configured_o (configured),
      .usb_en_o     (usb_en)
   );

   initial begin
      clk_i = 1'b0;
      forever #50 clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // expected device descriptor, 16-bit fields low byte first
   function automatic logic [7:0] descr_byte(input int i);
      logic [15:0] bcd_usb;
      logic [15:0] vid;
      logic [15:0] pid;
      logic [15:0] bcd_dev;
      bcd_usb = `USB_BCD_USB;
      vid     = `USB_VENDOR_ID;
      pid     = `USB_PRODUCT_ID;
      bcd_dev = `USB_BCD_DEVICE;
      case (i)
         0:       return 8'(`USB_DEV_DESCR_LEN);
         1:       return `USB_DESCR_DEVICE;
         2:       return bcd_usb[7:0];
         3:       return bcd_usb[15:8];
         4:       return `USB_DEV_CLASS;
         7:       return 8'(`USB_EP0_MAXPKT);
         8:       return vid[7:0];
         9:       return vid[15:8];
         10:      return pid[7:0];
         11:      return pid[15:8];
         12:      return bcd_dev[7:0];
         13:      return bcd_dev[15:8];
         17:      return 8'h01;      // one configuration
         default: return 8'h00;      // subclass, protocol, string indices
      endcase
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errors_before);
      if (errors == errors_before) begin
         $display("%s: ok", name);
      end else begin
         tests_failed++;
         $display("%s: failed with %0d errors", name, errors - errors_before);
      end
   endtask

   // one OUT-side strobe, then an idle cycle
   task automatic out_strobe(input logic [7:0] d, input logic valid, input logic stp,
                             input logic err, input logic ack);
      @(negedge clk_i);
      sie = '0;
      sie.out_data    = d;
      sie.out_valid   = valid;
      sie.setup       = stp;
      sie.out_err     = err;
      sie.in_data_ack = ack;
      sie.out_ready   = 1'b1;
      @(negedge clk_i);
      sie = '0;
   endtask

   task automatic send_setup(input logic [7:0] req_type, input logic [7:0] req,
                             input logic [15:0] value, input logic [15:0] index,
                             input logic [15:0] len, input int n);
      logic [63:0] pkt;
      pkt = {len, index, value, req, req_type};
      out_strobe(8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
      for (int i = 0; i < n; i++)
         out_strobe(pkt[8*i +: 8], 1'b1, 1'b0, 1'b0, 1'b0);
      out_strobe(8'h00, 1'b0, 1'b0, 1'b0, 1'b0);   // end of packet
      @(negedge clk_i);                           // req_done reaches the FSM
   endtask

   // IN data stage, stops on stall or after max_n bytes
   task automatic read_in(input int max_n, output int got, output logic stalled);
      logic done;
      got     = 0;
      stalled = 1'b0;
      done    = 1'b0;
      while (!done) begin
         @(negedge clk_i);
         sie.in_req = 1'b1;
         @(negedge clk_i);
         sie.in_req = 1'b0;
         if (stall) begin
            stalled = 1'b1;
            done    = 1'b1;
         end else if (in_pkt.valid) begin
            check("in_pkt_o.zlp", in_pkt.zlp, 0);
            rx_buf[got] = in_pkt.data;
            got++;
            sie.in_ready = 1'b1;
            @(negedge clk_i);
            sie.in_ready = 1'b0;
            done = (got >= max_n);
         end else begin
            errors++;
            $display("in_req at byte %0d was answered with neither data nor a stall", got);
            done = 1'b1;
         end
      end
      if (!stalled)
         out_strobe(8'h00, 1'b0, 1'b0, 1'b0, 1'b0);  // host status ZLP
   endtask

   task automatic status_ack(input logic ack);
      @(negedge clk_i);
      sie.in_req = 1'b1;
      @(negedge clk_i);
      sie.in_req = 1'b0;
      check("in_pkt_o.valid", in_pkt.valid, 1);
      check("in_pkt_o.zlp", in_pkt.zlp, 1);
      sie.in_ready = 1'b1;
      @(negedge clk_i);
      sie.in_ready = 1'b0;
      if (ack)
         out_strobe(8'h00, 1'b0, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic check_descr(input int n);
      for (int i = 0; i < n; i++)
         check($sformatf("in_pkt_o.data[%0d]", i), rx_buf[i], descr_byte(i));
   endtask

   task automatic get_config(input logic [7:0] exp);
      int   got;
      logic st;
      send_setup(8'h80, `USB_REQ_GET_CONFIGURATION, 16'h0000, 16'h0000, 16'd1, 8);
      read_in(1, got, st);
      check("GET_CONFIGURATION byte count", got, 1);
      check("in_pkt_o.data", rx_buf[0], exp);
   endtask

   task automatic set_config(input logic v);
      send_setup(8'h00, `USB_REQ_SET_CONFIGURATION, {15'd0, v}, 16'h0000, 16'd0, 8);
      status_ack(1'b1);
      check("configured_o", configured, v);
   endtask

   // stall must hold until a valid SETUP
   task automatic stall_then_clear(input string what);
      check({"stall_o after ", what}, stall, 1);
      repeat (3) @(negedge clk_i);
      check("stall_o held", stall, 1);
      send_setup(8'h80, `USB_REQ_GET_DESCRIPTOR, 16'h0100, 16'h0000, 16'd18, 8);
      check("stall_o cleared", stall, 0);
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      check("usb_en_o", usb_en, 0);
      check("stall_o", stall, 0);
      check("configured_o", configured, 0);
      check("addr_o", addr, 0);
      usb_reset = 1'b1;
      @(negedge clk_i);
      usb_reset = 1'b0;
      check("usb_en_o after bus reset", usb_en, 1);
      report_test("reset", e0);
   endtask

   task automatic test_descriptor();
      int   e0;
      int   got;
      logic st;
      e0 = errors;
      send_setup(8'h80, `USB_REQ_GET_DESCRIPTOR, 16'h0100, 16'h0000, 16'd64, 8);
      read_in(32, got, st);
      check("descriptor byte count", got, 18);
      check("stall_o after descriptor", st, 1);
      check_descr(got);
      send_setup(8'h80, `USB_REQ_GET_DESCRIPTOR, 16'h0100, 16'h0000, 16'd8, 8);
      read_in(16, got, st);
      check("short descriptor byte count", got, 8);
      check("stall_o on extra in_req", st, 1);
      check_descr(got);
      report_test("device descriptor", e0);
   endtask

   task automatic test_set_address();
      int                     e0;
      logic [`USB_ADDR_W-1:0] a1;
      logic [`USB_ADDR_W-1:0] a2;
      e0 = errors;
      rng = xorshift(rng);
      a1  = 7'((rng % 127) + 1);
      rng = xorshift(rng);
      a2  = 7'((rng % 127) + 1);
      if (a2 == a1)
         a2 = 7'((a1 % 127) + 1);
      send_setup(8'h00, `USB_REQ_SET_ADDRESS, {9'd0, a1}, 16'h0000, 16'd0, 8);
      status_ack(1'b1);
      check("addr_o", addr, a1);
      send_setup(8'h00, `USB_REQ_SET_ADDRESS, {9'd0, a2}, 16'h0000, 16'd0, 8);
      status_ack(1'b0);  // ZLP sent, host never ACKs
      repeat (2) @(negedge clk_i);
      check("addr_o without ACK", addr, a1);
      report_test("set address", e0);
   endtask

   task automatic test_configuration();
      int e0;
      e0 = errors;
      get_config(8'h00);
      set_config(1'b1);
      get_config(8'h01);
      set_config(1'b0);
      get_config(8'h00);
      report_test("configuration", e0);
   endtask

   task automatic test_unsupported();
      int e0;
      e0 = errors;
      send_setup(8'hA1, 8'h01, 16'h0000, 16'h0000, 16'd1, 8);   // class request
      stall_then_clear("class request");
      send_setup(8'h80, 8'h00, 16'h0000, 16'h0000, 16'd2, 8);   // GET_STATUS, not kept
      stall_then_clear("unknown bRequest");
      @(negedge clk_i);
      usb_reset = 1'b1;
      @(negedge clk_i);
      usb_reset = 1'b0;
      send_setup(8'h80, `USB_REQ_GET_CONFIGURATION, 16'h0000, 16'h0000, 16'd1, 8);
      stall_then_clear("GET_CONFIGURATION in default state");
      send_setup(8'h80, `USB_REQ_GET_DESCRIPTOR, 16'h0100, 16'h0000, 16'd18, 7);
      stall_then_clear("7-byte SETUP");
      report_test("unsupported requests", e0);
   endtask

   task automatic test_aborted_setup();
      int   e0;
      int   got;
      logic st;
      e0 = errors;
      out_strobe(8'h00, 1'b0, 1'b1, 1'b0, 1'b0);
      out_strobe(8'h80, 1'b1, 1'b0, 1'b0, 1'b0);
      out_strobe(`USB_REQ_GET_DESCRIPTOR, 1'b1, 1'b0, 1'b0, 1'b0);
      out_strobe(8'h00, 1'b1, 1'b0, 1'b0, 1'b0);
      out_strobe(8'h00, 1'b0, 1'b0, 1'b1, 1'b0);  // packet error mid-SETUP
      @(negedge clk_i);
      check("stall_o after abort", stall, 0);
      send_setup(8'h80, `USB_REQ_GET_DESCRIPTOR, 16'h0100, 16'h0000, 16'd18, 8);
      read_in(18, got, st);
      check("descriptor byte count", got, 18);
      check("stall_o", st, 0);
      check_descr(got);
      report_test("aborted setup", e0);
   endtask

   initial begin
      sie          = '0;
      usb_reset    = 1'b0;
      rstn         = 1'b0;
      rng          = 32'd86094;
      errors       = 0;
      checks       = 0;
      tests_failed = 0;
      cycle_cnt    = 0;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rstn = 1'b1;
      @(negedge clk_i);
      test_reset();
      test_descriptor();
      test_set_address();
      test_configuration();
      test_unsupported();
      test_aborted_setup();
      $display("6 tests, %0d failed, %0d checks, %0d errors", tests_failed, checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== testbench/usb_ctrl_endp_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_ctrl_endp_sva (
   input wire logic                  clk_i,
   input wire logic                  rstn,
   input wire logic                  usb_reset_i,
   input wire usb_ctrl_pkg::sie_rx_t sie_i,
   input wire usb_ctrl_pkg::in_pkt_t in_pkt_o,
   input wire logic                  stall_o
);

   // IN data answers the in_req of the cycle before
   a_valid_after_req: assert property (@(posedge clk_i) disable iff (!rstn)
      in_pkt_o.valid |-> $past(sie_i.in_req))
      else $error("in_pkt valid without in_req in the previous cycle");

   // a stalled endpoint offers neither data nor a ZLP
   a_no_data_in_stall: assert property (@(posedge clk_i) disable iff (!rstn)
      in_pkt_o.valid |-> !stall_o)
      else $error("in_pkt valid while stall_o is high");

   // only a new SETUP or a bus reset leaves the stall stage
   a_stall_release: assert property (@(posedge clk_i) disable iff (!rstn)
      $fell(stall_o) |->
         $past(sie_i.out_ready & sie_i.setup & ~sie_i.out_err) || $past(usb_reset_i))
      else $error("stall_o fell without a setup strobe");

endmodule

bind usb_ctrl_endp usb_ctrl_endp_sva u_sva (
   .clk_i       (clk_i),
   .rstn        (rstn),
   .usb_reset_i (usb_reset_i),
   .sie_i       (sie_i),
   .in_pkt_o    (in_pkt_o),
   .stall_o     (stall_o)
);

`default_nettype wire
